// ==== hw/exec_pkg.sv ====
// ----------------------------------------
// Execute unit shared definitions
// Opcodes, function codes, instruction word and command/result
// ----------------------------------------

package exec_pkg;

  // Data word width
  localparam int xlen_c = 32;

  // ----------------------------------------
  // Opcodes and function codes
  // ----------------------------------------

  // Major opcodes kept by the unit
  typedef enum logic [6:0] {
    op_reg = 7'b0110011,  // Register-register
    op_imm = 7'b0010011   // Register-immediate
  } opcode_e;

  // ALU function, same codes as the pipeline ALU select
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_or   = 4'd3,
    alu_slt  = 4'd4,
    alu_sltu = 4'd5,
    alu_and  = 4'd6,
    alu_xor  = 4'd7,
    alu_srl  = 4'd9,  // Code 8 left free
    alu_sra  = 4'd10
  } alu_fn_e;

  // Multiply/divide function
  typedef enum logic [2:0] {
    md_mul  = 3'd0,
    md_div  = 3'd1,
    md_divu = 3'd2,
    md_rem  = 3'd3,
    md_remu = 3'd4
  } md_fn_e;

  localparam logic [6:0] funct7_muldiv_c = 7'b0000001;  // M extension
  localparam logic [6:0] funct7_alt_c    = 7'b0100000;  // sub, sra

  // ----------------------------------------
  // Instruction word
  // ----------------------------------------

  // R-type fields
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  // I-type fields
  typedef struct packed {
    logic [11:0] imm12;  // Sign-extended immediate, shamt in low bits
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  // Same 32-bit word, two decodes
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

  // ----------------------------------------
  // Command and result
  // ----------------------------------------

  typedef struct packed {
    inst_u              inst;
    logic [xlen_c-1:0]  rs1_val;
    logic [xlen_c-1:0]  rs2_val;
  } exec_cmd_t;  // 96 bits

  typedef struct packed {
    logic [xlen_c-1:0]  data;
    logic               illegal;  // Opcode/funct not supported
  } exec_result_t;  // 33 bits

endpackage

// ==== hw/int_alu.sv ====
// ----------------------------------------
// Integer ALU
// Combinational, ten RV32I arithmetic/logic functions
// ----------------------------------------

`timescale 1ns/1ps

module int_alu (
  input  logic [exec_pkg::xlen_c-1:0] a,
  input  logic [exec_pkg::xlen_c-1:0] b,
  input  exec_pkg::alu_fn_e           fn,
  output logic [exec_pkg::xlen_c-1:0] y
);

  logic [4:0] shamt;  // Only low five bits shift
  logic       lt_s;   // Signed compare
  logic       lt_u;   // Unsigned compare

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  // ----------------------------------------
  // Function select
  // ----------------------------------------

  always_comb begin
    case (fn)
      exec_pkg::alu_add:  y = a + b;
      exec_pkg::alu_sub:  y = a - b;
      exec_pkg::alu_sll:  y = a << shamt;
      exec_pkg::alu_slt:  y = {{(exec_pkg::xlen_c-1){1'b0}}, lt_s};  // 1 or 0
      exec_pkg::alu_sltu: y = {{(exec_pkg::xlen_c-1){1'b0}}, lt_u};
      exec_pkg::alu_xor:  y = a ^ b;
      exec_pkg::alu_srl:  y = a >> shamt;
      // Arithmetic shift keeps the sign bit
      exec_pkg::alu_sra:  y = $signed(a) >>> shamt;
      exec_pkg::alu_or:   y = a | b;
      exec_pkg::alu_and:  y = a & b;
      default:            y = '0;  // Unused code
    endcase
  end

endmodule

// ==== hw/mul_div_iter.sv ====
// ----------------------------------------
// Iterative multiply/divide unit
// 32-step shift-add multiply, restoring divide, sign fixup
// ----------------------------------------

`timescale 1ns/1ps

module mul_div_iter (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,   // One-cycle launch pulse
  input  exec_pkg::md_fn_e              fn,
  input  logic [exec_pkg::xlen_c-1:0]   a,
  input  logic [exec_pkg::xlen_c-1:0]   b,
  output logic                          done,    // One-cycle completion pulse
  output logic [2*exec_pkg::xlen_c-1:0] result   // {high, low}
);

  logic                          busy;
  logic [4:0]                    count;      // Step index 0..31
  exec_pkg::md_fn_e              fn_q;
  logic                          neg_quo;    // Negate quotient at the end
  logic                          neg_rem;    // Negate remainder at the end

  // Shared datapath registers
  logic [exec_pkg::xlen_c-1:0]   acc;        // Product or partial remainder
  logic [exec_pkg::xlen_c-1:0]   shr;        // Multiplier or dividend/quotient
  logic [exec_pkg::xlen_c-1:0]   opr;        // Multiplicand or divisor

  logic                          is_signed;
  logic [exec_pkg::xlen_c-1:0]   a_mag;
  logic [exec_pkg::xlen_c-1:0]   b_mag;
  logic [exec_pkg::xlen_c:0]     rem_sh;     // Remainder with next dividend bit
  logic [exec_pkg::xlen_c+1:0]   diff;       // Trial subtraction
  logic [exec_pkg::xlen_c-1:0]   quo_fix;
  logic [exec_pkg::xlen_c-1:0]   rem_fix;

  // ----------------------------------------
  // Operand conditioning
  // ----------------------------------------

  assign is_signed = (fn == exec_pkg::md_div) || (fn == exec_pkg::md_rem);
  assign a_mag     = (is_signed && a[exec_pkg::xlen_c-1]) ? -a : a;
  assign b_mag     = (is_signed && b[exec_pkg::xlen_c-1]) ? -b : b;

  // Restoring step, negative diff means keep remainder
  assign rem_sh = {acc, shr[exec_pkg::xlen_c-1]};
  assign diff   = {1'b0, rem_sh} - {2'b00, opr};

  // ----------------------------------------
  // Step control
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 5'd1;
        if (count == 5'd31) begin  // Last step, done next cycle
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (start) begin
      fn_q    <= fn;
      // Signed quotient flips on sign mismatch, not for divide by zero
      neg_quo <= is_signed && (a[exec_pkg::xlen_c-1] ^ b[exec_pkg::xlen_c-1])
                 && (b != '0);
      neg_rem <= is_signed && a[exec_pkg::xlen_c-1];  // Follows dividend
      acc     <= '0;
      shr     <= a_mag;  // Magnitudes equal raw values for mul
      opr     <= b_mag;
    end else if (busy) begin
      if (fn_q == exec_pkg::md_mul) begin
        if (shr[0]) begin
          acc <= acc + opr;  // Low word only is kept
        end
        opr <= opr << 1;
        shr <= shr >> 1;
      end else if (!diff[exec_pkg::xlen_c+1]) begin
        acc <= diff[exec_pkg::xlen_c-1:0];  // Subtract fits
        shr <= {shr[exec_pkg::xlen_c-2:0], 1'b1};
      end else begin
        acc <= rem_sh[exec_pkg::xlen_c-1:0];  // Restore
        shr <= {shr[exec_pkg::xlen_c-2:0], 1'b0};
      end
    end
  end

  // Sign fixup on the way out
  assign quo_fix = neg_quo ? -shr : shr;
  assign rem_fix = neg_rem ? -acc : acc;

  // Low half mul/div/divu, high half rem/remu
  assign result = (fn_q == exec_pkg::md_mul) ? {{exec_pkg::xlen_c{1'b0}}, acc}
                                             : {rem_fix, quo_fix};

endmodule

// ==== hw/exec_issue.sv ====
// ----------------------------------------
// Execute issue controller
// Four-phase handshake, decode, path launch, result select
// ----------------------------------------

`timescale 1ns/1ps

module exec_issue (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req,
  input  exec_pkg::exec_cmd_t           cmd,
  output logic                          ack,
  output exec_pkg::exec_result_t        result,
  // ALU side
  output logic [exec_pkg::xlen_c-1:0]   alu_a,
  output logic [exec_pkg::xlen_c-1:0]   alu_b,
  output exec_pkg::alu_fn_e             alu_fn,
  input  logic [exec_pkg::xlen_c-1:0]   alu_y,
  // Multiply/divide side
  output logic                          md_start,
  output exec_pkg::md_fn_e              md_fn,
  output logic [exec_pkg::xlen_c-1:0]   md_a,
  output logic [exec_pkg::xlen_c-1:0]   md_b,
  input  logic                          md_done,
  input  logic [2*exec_pkg::xlen_c-1:0] md_result
);

  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_alu     = 2'd1;  // ALU result captured here
  localparam logic [1:0] st_md_wait = 2'd2;  // Waiting for done
  localparam logic [1:0] st_hold    = 2'd3;  // ack up, result held

  logic [1:0]                  state;
  logic                        accept;
  exec_pkg::exec_cmd_t         cmd_q;
  exec_pkg::alu_fn_e           alu_fn_q;
  exec_pkg::md_fn_e            md_fn_q;
  logic                        use_imm_q;
  logic                        illegal_q;
  exec_pkg::alu_fn_e           dec_alu_fn;
  exec_pkg::md_fn_e            dec_md_fn;
  logic                        dec_is_md;
  logic                        dec_use_imm;
  logic                        dec_illegal;
  logic [exec_pkg::xlen_c-1:0] md_word;

  // funct3 to ALU function, shared by OP and OP-IMM
  function automatic exec_pkg::alu_fn_e base_fn(input logic [2:0] f3);
    case (f3)
      3'b000:  return exec_pkg::alu_add;
      3'b001:  return exec_pkg::alu_sll;
      3'b010:  return exec_pkg::alu_slt;
      3'b011:  return exec_pkg::alu_sltu;
      3'b100:  return exec_pkg::alu_xor;
      3'b101:  return exec_pkg::alu_srl;
      3'b110:  return exec_pkg::alu_or;
      default: return exec_pkg::alu_and;
    endcase
  endfunction

  // ----------------------------------------
  // Decode of incoming word
  // ----------------------------------------

  always_comb begin
    dec_alu_fn  = base_fn(cmd.inst.r.funct3);
    dec_md_fn   = exec_pkg::md_mul;
    dec_is_md   = 1'b0;
    dec_use_imm = 1'b0;
    dec_illegal = 1'b0;
    case (cmd.inst.r.opcode)
      exec_pkg::op_reg: begin
        if (cmd.inst.r.funct7 == exec_pkg::funct7_muldiv_c) begin
          dec_is_md = 1'b1;
          case (cmd.inst.r.funct3)
            3'b000:  dec_md_fn = exec_pkg::md_mul;
            3'b100:  dec_md_fn = exec_pkg::md_div;
            3'b101:  dec_md_fn = exec_pkg::md_divu;
            3'b110:  dec_md_fn = exec_pkg::md_rem;
            3'b111:  dec_md_fn = exec_pkg::md_remu;
            default: begin  // mulh variants not supported
              dec_is_md   = 1'b0;
              dec_illegal = 1'b1;
            end
          endcase
        end else if (cmd.inst.r.funct7 == exec_pkg::funct7_alt_c) begin
          case (cmd.inst.r.funct3)
            3'b000:  dec_alu_fn = exec_pkg::alu_sub;
            3'b101:  dec_alu_fn = exec_pkg::alu_sra;
            default: dec_illegal = 1'b1;
          endcase
        end else if (cmd.inst.r.funct7 != 7'b0) begin
          dec_illegal = 1'b1;
        end
      end
      exec_pkg::op_imm: begin
        dec_use_imm = 1'b1;
        if (cmd.inst.i.funct3 == 3'b001) begin
          dec_illegal = cmd.inst.i.imm12[11:5] != 7'b0;  // slli
        end else if (cmd.inst.i.funct3 == 3'b101) begin
          // srli/srai, bit 10 picks arithmetic
          dec_illegal = (cmd.inst.i.imm12[11:5] & ~exec_pkg::funct7_alt_c) != 7'b0;
          dec_alu_fn  = cmd.inst.i.imm12[10] ? exec_pkg::alu_sra : exec_pkg::alu_srl;
        end
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  assign accept = (state == st_idle) && req;

  // ----------------------------------------
  // Handshake FSM
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      ack      <= 1'b0;
      md_start <= 1'b0;
    end else begin
      md_start <= 1'b0;  // Pulse only
      case (state)
        st_idle: begin
          if (req) begin
            md_start <= dec_is_md;
            state    <= dec_is_md ? st_md_wait : st_alu;
          end
        end
        st_alu: state <= st_hold;
        st_md_wait: begin
          if (md_done) begin
            ack   <= 1'b1;
            state <= st_hold;
          end
        end
        default: begin  // st_hold
          if (!ack) begin
            ack <= 1'b1;  // ALU path, second cycle
          end else if (!req) begin
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // Remainders sit in the high half
  assign md_word = (md_fn_q == exec_pkg::md_rem || md_fn_q == exec_pkg::md_remu)
                   ? md_result[2*exec_pkg::xlen_c-1:exec_pkg::xlen_c]
                   : md_result[exec_pkg::xlen_c-1:0];

  // Command and result registers
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q     <= cmd;
      alu_fn_q  <= dec_alu_fn;
      md_fn_q   <= dec_md_fn;
      use_imm_q <= dec_use_imm;
      illegal_q <= dec_illegal;
    end
    if (state == st_alu) begin
      result.data    <= illegal_q ? '0 : alu_y;  // Zero data when illegal
      result.illegal <= illegal_q;
    end else if (state == st_md_wait && md_done) begin
      result.data    <= md_word;
      result.illegal <= 1'b0;
    end
  end

  // Operands from the held command
  assign alu_a  = cmd_q.rs1_val;
  assign alu_b  = use_imm_q ? {{(exec_pkg::xlen_c-12){cmd_q.inst.i.imm12[11]}},
                               cmd_q.inst.i.imm12}
                            : cmd_q.rs2_val;
  assign alu_fn = alu_fn_q;
  assign md_fn  = md_fn_q;
  assign md_a   = cmd_q.rs1_val;
  assign md_b   = cmd_q.rs2_val;

endmodule

// ==== hw/exec_unit.sv ====
// ----------------------------------------
// Integer execute unit top
// Issue controller with ALU and multiply/divide side by side
// ----------------------------------------

`timescale 1ns/1ps

module exec_unit (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req,
  input  exec_pkg::exec_cmd_t    cmd,
  output logic                   ack,
  output exec_pkg::exec_result_t result
);

  // ALU wires
  logic [exec_pkg::xlen_c-1:0]   alu_a;
  logic [exec_pkg::xlen_c-1:0]   alu_b;
  exec_pkg::alu_fn_e             alu_fn;
  logic [exec_pkg::xlen_c-1:0]   alu_y;

  // Multiply/divide wires
  logic                          md_start;
  exec_pkg::md_fn_e              md_fn;
  logic [exec_pkg::xlen_c-1:0]   md_a;
  logic [exec_pkg::xlen_c-1:0]   md_b;
  logic                          md_done;
  logic [2*exec_pkg::xlen_c-1:0] md_result;

  exec_issue issue0 (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .cmd       (cmd),
    .ack       (ack),
    .result    (result),
    .alu_a     (alu_a),
    .alu_b     (alu_b),
    .alu_fn    (alu_fn),
    .alu_y     (alu_y),
    .md_start  (md_start),
    .md_fn     (md_fn),
    .md_a      (md_a),
    .md_b      (md_b),
    .md_done   (md_done),
    .md_result (md_result)
  );

  int_alu alu0 (
    .a  (alu_a),
    .b  (alu_b),
    .fn (alu_fn),
    .y  (alu_y)
  );

  mul_div_iter md0 (
    .clk    (clk),
    .reset  (reset),
    .start  (md_start),
    .fn     (md_fn),
    .a      (md_a),
    .b      (md_b),
    .done   (md_done),
    .result (md_result)
  );

endmodule

// ==== testbench/exec_unit_properties.sv ====
// ----------------------------------------
// Execute unit handshake properties
// Four-phase req/ack rules, bound to exec_unit
// ----------------------------------------

`timescale 1ns/1ps

module exec_unit_properties (
  input logic                   clk,
  input logic                   reset,
  input logic                   req,
  input logic                   ack,
  input exec_pkg::exec_result_t result
);

  int fail_count = 0;  // Read by the testbench at the end

  // ack is set on an edge that saw req high
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else begin
      fail_count++;
      $error("ack rose while req was low");
    end

  // Held result under back-pressure
  result_held: assert property (@(posedge clk) disable iff (reset)
    (ack && req) |=> $stable(result))
    else begin
      fail_count++;
      $error("result changed while ack and req were high");
    end

  // Release only after the requester lets go
  ack_falls_late: assert property (@(posedge clk) disable iff (reset)
    $fell(ack) |-> !$past(req))
    else begin
      fail_count++;
      $error("ack fell while req was still high");
    end

endmodule

bind exec_unit exec_unit_properties props0 (
  .clk    (clk),
  .reset  (reset),
  .req    (req),
  .ack    (ack),
  .result (result)
);

// ==== testbench/exec_unit_tb.sv ====
// ----------------------------------------
// Execute unit testbench
// Directed ALU, mul/div, illegal and back-pressure tests
// ----------------------------------------

`timescale 1ns/1ps

module exec_unit_tb;

  localparam int timeout_cycles = 100;  // Per wait, in clocks

  logic                   clk;
  logic                   reset;
  logic                   req;
  exec_pkg::exec_cmd_t    cmd;
  logic                   ack;
  exec_pkg::exec_result_t result;

  exec_unit dut0 (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .cmd    (cmd),
    .ack    (ack),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // ----------------------------------------
  // Reporting
  // ----------------------------------------

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: begin
        if (alt) return a - b;
        return a + b;
      end
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];  // Sign fill
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // RISC-V M rules incl. divide by zero and overflow
  function automatic logic [31:0] md_ref(input logic [2:0] f3,
                                         input logic [31:0] a, input logic [31:0] b);
    logic ovf;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (f3)
      3'b000: return a * b;  // Low word
      3'b100: begin
        if (b == 0) return 32'hffff_ffff;
        if (ovf) return a;
        return $signed(a) / $signed(b);
      end
      3'b101: return (b == 0) ? 32'hffff_ffff : a / b;
      3'b110: begin
        if (b == 0) return a;
        if (ovf) return 32'h0;
        return $signed(a) % $signed(b);  // Sign of dividend
      end
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  task automatic predict(input exec_pkg::exec_cmd_t c, output logic [31:0] data,
                         output logic illegal);
    logic [6:0]  op;
    logic [6:0]  f7;  // Also imm12[11:5]
    logic [2:0]  f3;
    logic [31:0] imm;
    op      = c.inst.r.opcode;
    f7      = c.inst.r.funct7;
    f3      = c.inst.r.funct3;
    imm     = {{20{c.inst.i.imm12[11]}}, c.inst.i.imm12};
    data    = '0;
    illegal = 1'b1;
    if (op == exec_pkg::op_imm) begin
      if (f3 == 3'b001) begin
        illegal = (f7 != 7'b0);
      end else if (f3 == 3'b101) begin
        illegal = (f7 != 7'b0) && (f7 != exec_pkg::funct7_alt_c);
      end else begin
        illegal = 1'b0;
      end
      if (!illegal) data = alu_ref(f3, (f3 == 3'b101) && f7[5], c.rs1_val, imm);
    end else if (op == exec_pkg::op_reg) begin
      if (f7 == 7'b0) begin
        illegal = 1'b0;
        data    = alu_ref(f3, 1'b0, c.rs1_val, c.rs2_val);
      end else if (f7 == exec_pkg::funct7_alt_c && (f3 == 3'b000 || f3 == 3'b101)) begin
        illegal = 1'b0;
        data    = alu_ref(f3, 1'b1, c.rs1_val, c.rs2_val);
      end else if (f7 == exec_pkg::funct7_muldiv_c && (f3 == 3'b000 || f3[2])) begin
        illegal = 1'b0;
        data    = md_ref(f3, c.rs1_val, c.rs2_val);
      end
    end
  endtask

  // ----------------------------------------
  // Handshake driving
  // ----------------------------------------

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (ack !== level) begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) begin
        fail_stop(level ? "Timeout waiting for ack to rise" : "Timeout waiting for ack to fall");
      end
    end
  endtask

  task automatic send_cmd(input exec_pkg::exec_cmd_t c, input int hold,
                          output exec_pkg::exec_result_t r);
    int i;
    @(negedge clk);
    cmd = c;
    req = 1'b1;
    wait_ack(1'b1);
    r = result;
    for (i = 0; i < hold; i++) begin  // Back-pressure, nothing may move
      @(negedge clk);
      check_value("ack", {31'b0, ack}, 32'd1);
      check_value("result.data", result.data, r.data);
      check_value("result.illegal", {31'b0, result.illegal}, {31'b0, r.illegal});
    end
    req = 1'b0;
    wait_ack(1'b0);
  endtask

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, exec_pkg::op_reg};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3);
    return {imm, 5'd1, f3, 5'd3, exec_pkg::op_imm};
  endfunction

  task automatic issue_and_check(input logic [31:0] word, input logic [31:0] a,
                                 input logic [31:0] b, input int hold);
    exec_pkg::exec_cmd_t    c;
    exec_pkg::exec_result_t r;
    logic [31:0]            exp_data;
    logic                   exp_ill;
    c.inst    = word;
    c.rs1_val = a;
    c.rs2_val = b;
    predict(c, exp_data, exp_ill);
    send_cmd(c, hold, r);
    check_value("result.data", r.data, exp_data);
    check_value("result.illegal", {31'b0, r.illegal}, {31'b0, exp_ill});
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic reset_idle_check();
    int i;
    for (i = 0; i < 5; i++) begin
      @(negedge clk);
      check_value("ack", {31'b0, ack}, 32'd0);
    end
  endtask

  task automatic reg_alu_ops();
    logic [6:0]  f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                              7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    logic [2:0]  f3s [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [31:0] ea [5] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h8000_0000};
    logic [31:0] eb [5] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'hffff_ffff, 32'h1f};
    int i;
    int j;
    for (i = 0; i < 10; i++) begin
      for (j = 0; j < 5; j++) begin
        issue_and_check(r_word(f7s[i], f3s[i]), ea[j], eb[j], 0);
      end
      for (j = 0; j < 4; j++) begin
        issue_and_check(r_word(f7s[i], f3s[i]), $urandom(), $urandom(), 0);
      end
    end
  endtask

  task automatic imm_alu_ops();
    logic [2:0]  f3s [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    logic [11:0] imms [4] = '{12'h7ff, 12'h800, 12'hfff, 12'h001};  // Incl. negatives
    logic [4:0]  shamts [4] = '{5'd0, 5'd1, 5'd17, 5'd31};
    logic [11:0] rimm;
    logic [31:0] a;
    int i;
    int j;
    for (i = 0; i < 6; i++) begin
      for (j = 0; j < 4; j++) begin
        issue_and_check(i_word(imms[j], f3s[i]), $urandom(), 32'h0, 0);
      end
      a    = $urandom();
      rimm = a[11:0];  // Random immediate
      issue_and_check(i_word(rimm, f3s[i]), $urandom(), 32'h0, 0);
    end
    for (j = 0; j < 4; j++) begin
      a = $urandom() | 32'h8000_0000;  // Sign set, sra differs from srl
      issue_and_check(i_word({7'h00, shamts[j]}, 3'b001), a, 32'h0, 0);  // slli
      issue_and_check(i_word({7'h00, shamts[j]}, 3'b101), a, 32'h0, 0);  // srli
      issue_and_check(i_word({7'h20, shamts[j]}, 3'b101), a, 32'h0, 0);  // srai
    end
  endtask

  task automatic muldiv_ops();
    logic [2:0] f3s [5] = '{3'd0, 3'd4, 3'd5, 3'd6, 3'd7};
    int i;
    int j;
    for (i = 0; i < 5; i++) begin
      for (j = 0; j < 4; j++) begin
        issue_and_check(r_word(exec_pkg::funct7_muldiv_c, f3s[i]), $urandom(), $urandom(), 0);
      end
      issue_and_check(r_word(exec_pkg::funct7_muldiv_c, f3s[i]), $urandom(), 32'h0, 0);
      issue_and_check(r_word(exec_pkg::funct7_muldiv_c, f3s[i]),
                      32'h8000_0000, 32'hffff_ffff, 0);  // Overflow case
      issue_and_check(r_word(exec_pkg::funct7_muldiv_c, f3s[i]), 32'hffff_fff9, 32'h2, 0);
      issue_and_check(r_word(exec_pkg::funct7_muldiv_c, f3s[i]), 32'h7, 32'hffff_fffe, 0);
    end
  endtask

  task automatic illegal_words();
    issue_and_check({25'h1abc, 7'b0000011}, $urandom(), $urandom(), 0);  // Load opcode
    issue_and_check(r_word(7'b0000010, 3'b000), $urandom(), $urandom(), 0);
    issue_and_check(r_word(exec_pkg::funct7_alt_c, 3'b001), $urandom(), $urandom(), 0);
    issue_and_check(r_word(exec_pkg::funct7_muldiv_c, 3'b001), $urandom(), $urandom(), 0);
    issue_and_check(i_word({7'h20, 5'd3}, 3'b001), $urandom(), 32'h0, 0);  // Bad slli
    issue_and_check(i_word({7'h40, 5'd3}, 3'b101), $urandom(), 32'h0, 0);  // Bad srli
  endtask

  task automatic held_req();
    issue_and_check(r_word(7'h00, 3'b000), $urandom(), $urandom(), 6);
    issue_and_check(r_word(exec_pkg::funct7_muldiv_c, 3'b100), $urandom(), $urandom(), 4);
    issue_and_check(r_word(exec_pkg::funct7_alt_c, 3'b000), $urandom(), $urandom(), 0);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    void'($urandom(2));
    reset = 1'b1;
    req   = 1'b0;
    cmd   = '0;
    repeat (3) @(posedge clk);  // Three reset edges
    @(negedge clk);
    reset = 1'b0;
    reset_idle_check();
    reg_alu_ops();
    imm_alu_ops();
    muldiv_ops();
    illegal_words();
    held_req();
    repeat (2) @(negedge clk);
    if (dut0.props0.fail_count != 0) begin
      fail_stop("A handshake assertion failed during the run");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
hw/exec_pkg.sv
hw/int_alu.sv
hw/mul_div_iter.sv
hw/exec_issue.sv
hw/exec_unit.sv
testbench/exec_unit_properties.sv
testbench/exec_unit_tb.sv
